//--- files.f
+incdir+verilog
verilog/agc_pkg.sv
verilog/agc_regs.sv
verilog/agc_stats.sv
verilog/agc_gain.sv
verilog/agc_top.sv
testbench/agc_tb.sv

//--- Makefile
TOP = agc_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir

//--- testbench/agc_tb.sv
`include "agc_defs.svh"

module agc_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import agc_pkg::*;

    localparam int SW         = $bits(sample_t);
    localparam int LW         = $bits(level_t);
    localparam int NROWS      = 5;
    localparam int WB_TIMEOUT = 20;
    localparam int DONE_POLLS = 100;

    typedef level_t [`AGC_NSAMP-1:0] lanes_t;

    // One stimulus row held for a whole window
    typedef struct packed {
        sample_t [`AGC_NSAMP-1:0] samp;
        scale_t                   scale;
        offset_t                  offset;
        logic                     en;
        lanes_t                   lvl;
        cnt_acc_t                 gt;
        cnt_acc_t                 lt;
        sq_acc_t                  sq;
    } row_t;

    logic                     aclk;
    logic                     rst_n_i;
    logic                     wb_cyc_i;
    logic                     wb_stb_i;
    logic                     wb_we_i;
    logic [7:0]               wb_adr_i;
    logic [31:0]              wb_dat_i;
    logic [3:0]               wb_sel_i;
    logic                     wb_ack_o;
    logic [31:0]              wb_dat_o;
    logic                     chan_en_i;
    logic [`AGC_NSAMP*SW-1:0] data_i;
    logic [`AGC_NSAMP*LW-1:0] data_o;

    row_t        rows [NROWS];
    logic [31:0] lfsr_state;

    agc_top agc_top_i (
        .aclk      (aclk),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_ack_o  (wb_ack_o),
        .wb_dat_o  (wb_dat_o),
        .chan_en_i (chan_en_i),
        .data_i    (data_i),
        .data_o    (data_o)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    task automatic halt_with_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0t: %s", $time, why);
        halt_with_failure();
    endtask

    task automatic check_level(input string name, input level_t got, input level_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            halt_with_failure();
        end
    endtask

    task automatic check_sq(input string name, input sq_acc_t got, input sq_acc_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            halt_with_failure();
        end
    endtask

    task automatic check_cnt(input string name, input cnt_acc_t got, input cnt_acc_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            halt_with_failure();
        end
    endtask

    task automatic check_scale(input string name, input scale_t got, input scale_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            halt_with_failure();
        end
    endtask

    task automatic check_offset(input string name, input offset_t got, input offset_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            halt_with_failure();
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < nbits; k++) begin
            val = {val[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return val;
    endfunction

    // Level before saturation is floor((s * scale + offset * 256) / 65536)
    function automatic longint raw_level(input sample_t s, input scale_t sc, input offset_t off);
        longint acc;
        acc = longint'(s) * longint'(sc) + (longint'(off) <<< 8);
        return acc >>> 16;
    endfunction

    function automatic level_t expect_level(input sample_t s, input scale_t sc,
                                            input offset_t off, input logic en);
        longint lv;
        lv = raw_level(s, sc, off);
        if (!en) return level_t'(16);
        if (lv > 15) lv = 15;
        else if (lv < -16) lv = -16;
        return level_t'(lv + 16);
    endfunction

    function automatic lanes_t levels_for(input int r, input scale_t sc, input offset_t off);
        lanes_t lv;
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            lv[i] = expect_level(rows[r].samp[i], sc, off, rows[r].en);
        end
        return lv;
    endfunction

    task automatic set_row(input int r, input sample_t s0, input sample_t s1,
                           input sample_t s2, input sample_t s3,
                           input scale_t sc, input offset_t off, input logic en);
        rows[r].samp   = {s3, s2, s1, s0};
        rows[r].scale  = sc;
        rows[r].offset = off;
        rows[r].en     = en;
    endtask

    // Window sums follow from constant samples held for the whole window
    task automatic fill_expected(input int r);
        sample_t s;
        longint  lv;
        int      top;
        int      sq_sum;
        int      nhi;
        int      nlo;
        sq_sum = 0;
        nhi    = 0;
        nlo    = 0;
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            s   = rows[r].samp[i];
            lv  = raw_level(s, rows[r].scale, rows[r].offset);
            top = int'(s) >>> 4;
            sq_sum += top * top;
            if (lv > 15) nhi++;
            if (lv < -16) nlo++;
        end
        rows[r].lvl = levels_for(r, rows[r].scale, rows[r].offset);
        rows[r].sq  = sq_acc_t'(sq_sum * `AGC_WINDOW);
        rows[r].gt  = cnt_acc_t'(nhi * `AGC_WINDOW);
        rows[r].lt  = cnt_acc_t'(nlo * `AGC_WINDOW);
    endtask

    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int waited;
        @(negedge aclk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = sel;
        waited   = 0;
        do begin
            @(negedge aclk);
            waited++;
            if (waited > WB_TIMEOUT) abort_run("Wishbone access was never acknowledged");
        end while (!wb_ack_o);
        rdat = wb_dat_o;
        // Request stays up through the clock edge that samples ack
        @(negedge aclk);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdat, input logic [3:0] sel);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, sel, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 32'd0, 4'hF, rdat);
    endtask

    task automatic wait_window_done();
        logic [31:0] ctrl;
        int          polls;
        ctrl  = '0;
        polls = 0;
        while (!ctrl[1]) begin
            if (polls > DONE_POLLS) abort_run("measurement window never reported done");
            wb_read(`AGC_ADDR_CTRL, ctrl);
            polls++;
        end
    endtask

    // Gain pipeline is two clocks deep and the apply strobe takes one more
    task automatic settle();
        repeat (3) @(negedge aclk);
    endtask

    task automatic drive_row(input int r);
        @(negedge aclk);
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            data_i[i*SW +: SW] = rows[r].samp[i];
        end
        chan_en_i = rows[r].en;
    endtask

    task automatic check_lanes(input lanes_t exp);
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            check_level($sformatf("data_o[%0d]", i), data_o[i*LW +: LW], exp[i]);
        end
    endtask

    initial begin
        logic [31:0] rdat;
        scale_t      cur_scale;
        offset_t     cur_offset;
        rst_n_i    = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        wb_sel_i   = '0;
        chan_en_i  = 1'b1;
        data_i     = '0;
        lfsr_state = 32'd78062;
        cur_scale  = `AGC_SCALE_RESET;
        cur_offset = '0;

        // Reset gain then unity gain into both rails then 1/16 with offset
        set_row(0, 12'sd100, -12'sd300, 12'sd2047, -12'sd2048, 17'h00200, 16'sh0000, 1'b1);
        set_row(1, 12'sd5, -12'sd7, 12'sd300, -12'sd300, 17'h10000, 16'sh0000, 1'b1);
        set_row(2, 12'sd40, -12'sd40, 12'sd500, -12'sd1000, 17'h01000, 16'sh0180, 1'b1);
        set_row(3, 12'sd40, -12'sd40, 12'sd500, -12'sd1000, 17'h01000, 16'sh0180, 1'b0);
        set_row(4, sample_t'(lfsr_take(SW)), sample_t'(lfsr_take(SW)),
                sample_t'(lfsr_take(SW)), sample_t'(lfsr_take(SW)),
                17'h00800, -16'sh0100, 1'b1);
        for (int r = 0; r < NROWS; r++) begin
            fill_expected(r);
        end

        repeat (16) @(negedge aclk);
        rst_n_i = 1'b1;

        wb_read(`AGC_ADDR_SCALE, rdat);
        check_scale("scale after reset", rdat[16:0], `AGC_SCALE_RESET);

        for (int r = 0; r < NROWS; r++) begin
            drive_row(r);
            wb_write(`AGC_ADDR_SCALE, {15'd0, rows[r].scale}, 4'hF);
            wb_write(`AGC_ADDR_OFFSET, {16'd0, rows[r].offset}, 4'hF);
            wb_write(`AGC_ADDR_CTRL, 32'h0000_0300, 4'hF);
            settle();
            // Loaded but not applied so the old gain is still active
            check_lanes(levels_for(r, cur_scale, cur_offset));
            wb_write(`AGC_ADDR_CTRL, 32'h0000_0400, 4'hF);
            settle();
            cur_scale  = rows[r].scale;
            cur_offset = rows[r].offset;
            check_lanes(rows[r].lvl);

            wb_write(`AGC_ADDR_CTRL, 32'h0000_0001, 4'hF);
            wait_window_done();
            wb_read(`AGC_ADDR_SQ, rdat);
            check_sq("sq", rdat[24:0], rows[r].sq);
            wb_read(`AGC_ADDR_GT, rdat);
            check_cnt("gt", rdat[20:0], rows[r].gt);
            wb_read(`AGC_ADDR_LT, rdat);
            check_cnt("lt", rdat[20:0], rows[r].lt);
        end

        wb_write(`AGC_ADDR_CTRL, 32'h0000_0004, 4'h1);
        wb_read(`AGC_ADDR_SQ, rdat);
        check_sq("sq after clear", rdat[24:0], '0);
        wb_read(`AGC_ADDR_GT, rdat);
        check_cnt("gt after clear", rdat[20:0], '0);
        wb_read(`AGC_ADDR_LT, rdat);
        check_cnt("lt after clear", rdat[20:0], '0);

        // Byte lanes of OFFSET
        wb_write(`AGC_ADDR_OFFSET, 32'h0000_1234, 4'hF);
        wb_write(`AGC_ADDR_OFFSET, 32'h0000_ABCD, 4'h1);
        wb_read(`AGC_ADDR_OFFSET, rdat);
        check_offset("offset low byte", rdat[15:0], 16'h12CD);
        wb_write(`AGC_ADDR_OFFSET, 32'h0000_56EF, 4'h2);
        wb_read(`AGC_ADDR_OFFSET, rdat);
        check_offset("offset high byte", rdat[15:0], 16'h56CD);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verilog/agc_top.sv
`include "agc_defs.svh"

module agc_top (
    input  logic                                           aclk,
    input  logic                                           rst_n_i,
    input  logic                                           wb_cyc_i,
    input  logic                                           wb_stb_i,
    input  logic                                           wb_we_i,
    input  logic [7:0]                                     wb_adr_i,
    input  logic [31:0]                                    wb_dat_i,
    input  logic [3:0]                                     wb_sel_i,
    output logic                                           wb_ack_o,
    output logic [31:0]                                    wb_dat_o,
    input  logic                                           chan_en_i,
    input  logic [`AGC_NSAMP*$bits(agc_pkg::sample_t)-1:0] data_i,
    output logic [`AGC_NSAMP*$bits(agc_pkg::level_t)-1:0]  data_o
);
    import agc_pkg::*;

    // Register block to statistics
    logic     start;
    logic     clear;
    logic     done;
    sq_acc_t  sq;
    cnt_acc_t gt;
    cnt_acc_t lt;

    // Register block to gain datapath
    logic     load_scale;
    logic     load_offset;
    logic     apply;
    scale_t   scale;
    offset_t  offset;

    // Clip flags from gain to statistics
    logic [`AGC_NSAMP-1:0] hi;
    logic [`AGC_NSAMP-1:0] lo;

    agc_regs u_regs (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .done_i        (done),
        .sq_i          (sq),
        .gt_i          (gt),
        .lt_i          (lt),
        .start_o       (start),
        .clear_o       (clear),
        .load_scale_o  (load_scale),
        .load_offset_o (load_offset),
        .apply_o       (apply),
        .scale_o       (scale),
        .offset_o      (offset)
    );

    agc_stats u_stats (
        .aclk    (aclk),
        .rst_n_i (rst_n_i),
        .start_i (start),
        .clear_i (clear),
        .data_i  (data_i),
        .hi_i    (hi),
        .lo_i    (lo),
        .done_o  (done),
        .sq_o    (sq),
        .gt_o    (gt),
        .lt_o    (lt)
    );

    agc_gain u_gain (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .chan_en_i     (chan_en_i),
        .data_i        (data_i),
        .scale_i       (scale),
        .offset_i      (offset),
        .load_scale_i  (load_scale),
        .load_offset_i (load_offset),
        .apply_i       (apply),
        .data_o        (data_o),
        .hi_o          (hi),
        .lo_o          (lo)
    );

endmodule

//--- verilog/agc_gain.sv
`include "agc_defs.svh"

module agc_gain (
    input  logic                                          aclk,
    input  logic                                          rst_n_i,
    input  logic                                          chan_en_i,
    input  logic [`AGC_NSAMP*$bits(agc_pkg::sample_t)-1:0] data_i,
    input  agc_pkg::scale_t                               scale_i,
    input  agc_pkg::offset_t                              offset_i,
    input  logic                                          load_scale_i,
    input  logic                                          load_offset_i,
    input  logic                                          apply_i,
    output logic [`AGC_NSAMP*$bits(agc_pkg::level_t)-1:0]  data_o,
    output logic [`AGC_NSAMP-1:0]                         hi_o,
    output logic [`AGC_NSAMP-1:0]                         lo_o
);
    import agc_pkg::*;

    localparam int     SW       = $bits(sample_t);
    localparam int     LW       = $bits(level_t);
    localparam level_t LVL_ZERO = 5'b10000;

    scale_t             scale_stg;
    scale_t             scale_act;
    offset_t            offset_stg;
    offset_t            offset_act;
    sample_t            samp;
    logic signed [30:0] samp_w;
    logic signed [30:0] scale_w;
    logic signed [30:0] off_w;
    logic signed [30:0] mac [`AGC_NSAMP];
    logic signed [30:0] mac_q [`AGC_NSAMP];
    logic signed [14:0] lvl_w;
    logic signed [4:0]  sat;
    level_t             lvl [`AGC_NSAMP];
    logic [`AGC_NSAMP-1:0] hi_d;
    logic [`AGC_NSAMP-1:0] lo_d;

    // Staged then active gain, so all lanes switch on the same clock
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scale_stg  <= `AGC_SCALE_RESET;
            scale_act  <= `AGC_SCALE_RESET;
            offset_stg <= '0;
            offset_act <= '0;
        end else begin
            if (load_scale_i) scale_stg <= scale_i;
            if (load_offset_i) offset_stg <= offset_i;
            if (apply_i) begin
                scale_act  <= scale_stg;
                offset_act <= offset_stg;
            end
        end
    end

    // Stage 1: sample * scale + offset * 256
    always_comb begin
        scale_w = {14'd0, scale_act};
        off_w   = {{7{offset_act[15]}}, offset_act, 8'd0};
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            samp   = data_i[i*SW +: SW];
            samp_w = {{19{samp[SW-1]}}, samp};
            mac[i] = samp_w * scale_w + off_w;
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            mac_q[i] <= mac[i];
        end
    end

    // Stage 2: drop 16 fraction bits, saturate to -16..15
    always_comb begin
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            lvl_w   = mac_q[i][30:16];
            hi_d[i] = (lvl_w > 15);
            lo_d[i] = (lvl_w < -16);
            if (hi_d[i]) begin
                sat = 5'sd15;
            end else if (lo_d[i]) begin
                sat = -5'sd16;
            end else begin
                sat = lvl_w[4:0];
            end
            // Offset binary is the flipped sign bit
            lvl[i] = {~sat[4], sat[3:0]};
        end
    end

    // Muted lanes sit at mid-scale
    always_ff @(posedge aclk) begin
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            data_o[i*LW +: LW] <= chan_en_i ? lvl[i] : LVL_ZERO;
        end
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            hi_o <= hi_d;
            lo_o <= lo_d;
        end
    end

endmodule

//--- verilog/agc_stats.sv
`include "agc_defs.svh"

module agc_stats (
    input  logic                                           aclk,
    input  logic                                           rst_n_i,
    input  logic                                           start_i,
    input  logic                                           clear_i,
    input  logic [`AGC_NSAMP*$bits(agc_pkg::sample_t)-1:0] data_i,
    input  logic [`AGC_NSAMP-1:0]                          hi_i,
    input  logic [`AGC_NSAMP-1:0]                          lo_i,
    output logic                                           done_o,
    output agc_pkg::sq_acc_t                               sq_o,
    output agc_pkg::cnt_acc_t                              gt_o,
    output agc_pkg::cnt_acc_t                              lt_o
);
    import agc_pkg::*;

    localparam int SW = $bits(sample_t);
    localparam int TW = $clog2(`AGC_WINDOW + 1);
    localparam int NW = $clog2(`AGC_NSAMP + 1);

    logic [TW-1:0]      cnt;
    logic [TW-1:0]      cnt_nxt;
    logic               run;
    logic               active;
    logic [1:0]         active_d;
    sample_t            lane;
    logic signed [15:0] top_w;
    logic [15:0]        lane_sq;
    sq_acc_t            sq_sum;
    logic [NW-1:0]      hi_n;
    logic [NW-1:0]      lo_n;

    // The start clock itself is the first window clock
    assign active  = start_i || run;
    assign cnt_nxt = start_i ? TW'(1) : cnt + 1'b1;

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt      <= '0;
            run      <= 1'b0;
            active_d <= '0;
            done_o   <= 1'b0;
        end else begin
            if (active) begin
                cnt <= cnt_nxt;
                run <= (cnt_nxt != TW'(`AGC_WINDOW));
            end
            // Clip flags trail the samples by the gain pipeline depth
            active_d <= {active_d[0], active};
            done_o   <= active_d[1] && !active_d[0];
        end
    end

    // Per-clock lane sums
    always_comb begin
        sq_sum = '0;
        hi_n   = '0;
        lo_n   = '0;
        for (int i = 0; i < `AGC_NSAMP; i++) begin
            lane    = data_i[i*SW +: SW];
            top_w   = {{8{lane[SW-1]}}, lane[SW-1 -: 8]};
            lane_sq = top_w * top_w;
            sq_sum  = sq_sum + sq_acc_t'(lane_sq);
            hi_n    = hi_n + NW'(hi_i[i]);
            lo_n    = lo_n + NW'(lo_i[i]);
        end
    end

    // Accumulators restart with each window
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sq_o <= '0;
            gt_o <= '0;
            lt_o <= '0;
        end else if (clear_i) begin
            sq_o <= '0;
            gt_o <= '0;
            lt_o <= '0;
        end else begin
            if (active) sq_o <= start_i ? sq_sum : sq_o + sq_sum;
            if (start_i) begin
                gt_o <= '0;
                lt_o <= '0;
            end else if (active_d[1]) begin
                gt_o <= gt_o + cnt_acc_t'(hi_n);
                lt_o <= lt_o + cnt_acc_t'(lo_n);
            end
        end
    end

    window_bound: assert property (@(posedge aclk) disable iff (!rst_n_i)
        cnt <= TW'(`AGC_WINDOW));

endmodule

//--- verilog/agc_regs.sv
`include "agc_defs.svh"

module agc_regs (
    input  logic              aclk,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [7:0]        wb_adr_i,
    input  logic [31:0]       wb_dat_i,
    input  logic [3:0]        wb_sel_i,
    output logic              wb_ack_o,
    output logic [31:0]       wb_dat_o,
    input  logic              done_i,
    input  agc_pkg::sq_acc_t  sq_i,
    input  agc_pkg::cnt_acc_t gt_i,
    input  agc_pkg::cnt_acc_t lt_i,
    output logic              start_o,
    output logic              clear_o,
    output logic              load_scale_o,
    output logic              load_offset_o,
    output logic              apply_o,
    output agc_pkg::scale_t   scale_o,
    output agc_pkg::offset_t  offset_o
);
    import agc_pkg::*;

    localparam logic [7:0] ADDR_CTRL   = `AGC_ADDR_CTRL;
    localparam logic [7:0] ADDR_SQ     = `AGC_ADDR_SQ;
    localparam logic [7:0] ADDR_GT     = `AGC_ADDR_GT;
    localparam logic [7:0] ADDR_LT     = `AGC_ADDR_LT;
    localparam logic [7:0] ADDR_SCALE  = `AGC_ADDR_SCALE;
    localparam logic [7:0] ADDR_OFFSET = `AGC_ADDR_OFFSET;

    wb_state_t   state;
    logic [2:0]  reg_sel;
    logic        req;
    logic        ctrl_wr;
    logic [31:0] rd_mux;
    logic [31:0] rd_hold;
    logic        done_q;
    sq_acc_t     sq_snap;
    cnt_acc_t    gt_snap;
    cnt_acc_t    lt_snap;

    assign reg_sel = wb_adr_i[4:2];
    // New access only from IDLE and not while the previous ack is still out
    assign req     = wb_cyc_i && wb_stb_i && (state == IDLE) && !wb_ack_o;
    assign ctrl_wr = req && wb_we_i && (reg_sel == ADDR_CTRL[4:2]);

    // Access FSM with registered ack
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= IDLE;
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= (state == ACK);
            case (state)
                IDLE:        if (req) state <= wb_we_i ? WRITE : READ;
                WRITE, READ: state <= ACK;
                ACK:         state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    // Control strobes, one clock after the bus sample
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            start_o       <= 1'b0;
            clear_o       <= 1'b0;
            load_scale_o  <= 1'b0;
            load_offset_o <= 1'b0;
            apply_o       <= 1'b0;
        end else begin
            start_o       <= ctrl_wr && wb_sel_i[0] && wb_dat_i[0];
            clear_o       <= ctrl_wr && wb_sel_i[0] && wb_dat_i[2];
            load_scale_o  <= ctrl_wr && wb_sel_i[1] && wb_dat_i[8];
            load_offset_o <= ctrl_wr && wb_sel_i[1] && wb_dat_i[9];
            apply_o       <= ctrl_wr && wb_sel_i[1] && wb_dat_i[10];
        end
    end

    // Pending gain values, byte-wise writes
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scale_o  <= `AGC_SCALE_RESET;
            offset_o <= '0;
        end else if (state == WRITE) begin
            if (reg_sel == ADDR_SCALE[4:2]) begin
                if (wb_sel_i[0]) scale_o[7:0]  <= wb_dat_i[7:0];
                if (wb_sel_i[1]) scale_o[15:8] <= wb_dat_i[15:8];
                if (wb_sel_i[2]) scale_o[16]   <= wb_dat_i[16];
            end
            if (reg_sel == ADDR_OFFSET[4:2]) begin
                if (wb_sel_i[0]) offset_o[7:0]  <= wb_dat_i[7:0];
                if (wb_sel_i[1]) offset_o[15:8] <= wb_dat_i[15:8];
            end
        end
    end

    // Status: done flag and statistics snapshot
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q  <= 1'b0;
            sq_snap <= '0;
            gt_snap <= '0;
            lt_snap <= '0;
        end else begin
            if (start_o) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
            if (clear_o) begin
                sq_snap <= '0;
                gt_snap <= '0;
                lt_snap <= '0;
            end else if (done_i) begin
                sq_snap <= sq_i;
                gt_snap <= gt_i;
                lt_snap <= lt_i;
            end
        end
    end

    always_comb begin
        case (reg_sel)
            ADDR_CTRL[4:2]:   rd_mux = {30'd0, done_q, 1'b0};
            ADDR_SQ[4:2]:     rd_mux = {7'd0, sq_snap};
            ADDR_GT[4:2]:     rd_mux = {11'd0, gt_snap};
            ADDR_LT[4:2]:     rd_mux = {11'd0, lt_snap};
            ADDR_SCALE[4:2]:  rd_mux = {15'd0, scale_o};
            ADDR_OFFSET[4:2]: rd_mux = {16'd0, offset_o};
            default:          rd_mux = '0;
        endcase
    end

    // Read data captured in READ and held through the ack
    always_ff @(posedge aclk) begin
        if (state == READ) rd_hold <= rd_mux;
    end

    assign wb_dat_o = rd_hold;

    ack_within_cycle: assert property (@(posedge aclk) disable iff (!rst_n_i)
        wb_ack_o |-> wb_cyc_i);

    ack_single_pulse: assert property (@(posedge aclk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

//--- verilog/agc_pkg.sv
package agc_pkg;

    // Raw digitizer sample
    typedef logic signed [11:0] sample_t;

    // Quantized output, offset binary with 16 as zero
    typedef logic [4:0] level_t;

    // Unsigned gain, 1.0 at 0x10000
    typedef logic [16:0] scale_t;

    // Signed offset in 1/256 of an output step
    typedef logic signed [15:0] offset_t;

    // Window statistics
    typedef logic [24:0] sq_acc_t;
    typedef logic [20:0] cnt_acc_t;

    // Bus access sequencing
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        ACK
    } wb_state_t;

endpackage

//--- verilog/agc_defs.svh
`ifndef AGC_DEFS_SVH
`define AGC_DEFS_SVH

// Lanes processed per clock
`define AGC_NSAMP 4

// Measurement window length in clocks
`define AGC_WINDOW 64

// Register byte offsets
// Only address bits 4 to 2 take part in the decode
`define AGC_ADDR_CTRL   8'h00
`define AGC_ADDR_SQ     8'h04
`define AGC_ADDR_GT     8'h08
`define AGC_ADDR_LT     8'h0C
`define AGC_ADDR_SCALE  8'h10
`define AGC_ADDR_OFFSET 8'h14

// Reset gain gives one output step per 128 input codes
`define AGC_SCALE_RESET 17'h00200

`endif
